/* filelist.f */
+incdir+hw
hw/sdp_rdma_pkg.sv
hw/sdp_rdma_ig_ctrl.sv
hw/sdp_rdma_cube_walk.sv
hw/sdp_rdma_addr_gen.sv
hw/sdp_rdma_req_size.sv
hw/sdp_rdma_stall_cnt.sv
hw/sdp_rdma_ig.sv
testbench/tb_sdp_rdma_ig.sv

/* hw/sdp_rdma_addr_gen.sv */
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_addr_gen (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  logic                        op_load,
  input  logic                        accept,
  input  sdp_rdma_pkg::rdma_cfg_t     cfg,
  input  sdp_rdma_pkg::cube_pos_t     pos,
  output logic [`SDP_RDMA_ADDR_W-1:0] addr
);

  logic [`SDP_RDMA_ATOM_ADDR_W-1:0] cfg_base_addr;
  logic [`SDP_RDMA_ATOM_ADDR_W-1:0] base_addr_line;
  logic [`SDP_RDMA_ATOM_ADDR_W-1:0] base_addr_surf;
  logic                             mon_line_c;
  logic                             mon_surf_c;

  // base address in atoms
  assign cfg_base_addr = {cfg.base_addr_high, cfg.base_addr_low};

  // ==================
  // line base
  // ==================

  // steps by line stride, jumps to next surface at surf end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_line <= '0;
      mon_line_c     <= 1'b0;
    end else if (op_load) begin
      base_addr_line <= cfg_base_addr;
      mon_line_c     <= 1'b0;
    end else if (accept) begin
      if (pos.surf_end) begin
        {mon_line_c, base_addr_line} <= base_addr_surf + cfg.surface_stride;
      end else if (pos.line_end) begin
        {mon_line_c, base_addr_line} <= base_addr_line + cfg.line_stride;
      end
    end
  end

  // ==================
  // surface base
  // ==================

  // first line of the current surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_surf <= '0;
      mon_surf_c     <= 1'b0;
    end else if (op_load) begin
      base_addr_surf <= cfg_base_addr;
      mon_surf_c     <= 1'b0;
    end else if (accept && pos.surf_end) begin
      {mon_surf_c, base_addr_surf} <= base_addr_surf + cfg.surface_stride;
    end
  end

  // back to bytes, atom aligned
  assign addr = {base_addr_line, {`SDP_RDMA_ATOM_SHIFT{1'b0}}};

  // carry out of either base is an overflow
  a_line_no_ovf: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !mon_line_c)
    else $error("line base address overflow");

  a_surf_no_ovf: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !mon_surf_c)
    else $error("surface base address overflow");

endmodule

/* hw/sdp_rdma_cube_walk.sv */
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_cube_walk (
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,
  input  logic                            accept,
  input  sdp_rdma_pkg::rdma_cfg_t         cfg,
  input  logic [`SDP_RDMA_SURF_CNT_W-1:0] surf_cnt,
  output sdp_rdma_pkg::cube_pos_t         pos
);

  logic [`SDP_RDMA_SURF_CNT_W-1:0] count_c;
  logic [`SDP_RDMA_DIM_W-1:0]      count_h;
  logic                            mode_per_kernel;
  logic                            mode_1x1_pack;
  logic                            is_last_c;
  logic                            is_last_h;

  // ==================
  // mode decode
  // ==================

  // data_mode 0 means one request per kernel
  assign mode_per_kernel = (cfg.data_mode == 1'b0);
  // 1x1 cube packs into one straight read
  assign mode_1x1_pack   = (cfg.width == '0) && (cfg.height == '0);

  // ==================
  // end flags
  // ==================

  assign is_last_h = (count_h == cfg.height);
  assign is_last_c = (count_c == surf_cnt);

  // every request covers a full line
  assign pos.line_end = 1'b1;
  // straight modes end surface and cube at once
  assign pos.surf_end = mode_1x1_pack | mode_per_kernel | (pos.line_end & is_last_h);
  assign pos.cube_end = mode_1x1_pack | mode_per_kernel | (pos.surf_end & is_last_c);

  // ==================
  // counters
  // ==================

  // channel, one step per surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (accept) begin
      if (pos.cube_end) begin
        count_c <= '0;
      end else if (pos.surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // height, one step per line
  // wraps back at surface end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (accept) begin
      if (pos.surf_end) begin
        count_h <= '0;
      end else if (pos.line_end) begin
        count_h <= count_h + 1'b1;
      end
    end
  end

endmodule

/* hw/sdp_rdma_ig.sv */
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_ig (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic                         op_load,
  input  logic                         reg2dp_op_en,
  input  logic                         reg2dp_perf_dma_en,
  input  sdp_rdma_pkg::rdma_cfg_t      cfg,
  output sdp_rdma_pkg::dma_rd_req_t    dma_rd_req_pd,
  output logic                         dma_rd_req_vld,
  input  logic                         dma_rd_req_rdy,
  output sdp_rdma_pkg::cq_entry_t      ig2cq_pd,
  output logic                         ig2cq_pvld,
  input  logic                         ig2cq_prdy,
  output logic [`SDP_RDMA_STALL_W-1:0] dp2reg_rdma_stall
);

  import sdp_rdma_pkg::*;

  logic                            accept;
  cube_pos_t                       pos;
  logic [`SDP_RDMA_SURF_CNT_W-1:0] surf_cnt;
  logic [`SDP_RDMA_SIZE_W-1:0]     req_size;
  logic [`SDP_RDMA_ADDR_W-1:0]     req_addr;

  // ==================
  // control
  // ==================

  sdp_rdma_ig_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cube_end        (pos.cube_end),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .ig2cq_prdy      (ig2cq_prdy),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .ig2cq_pvld      (ig2cq_pvld),
    .accept          (accept)
  );

  // ==================
  // datapath
  // ==================

  // size and surface count, combinational
  sdp_rdma_req_size u_req_size (
    .cfg             (cfg),
    .reg2dp_op_en    (reg2dp_op_en),
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .surf_cnt        (surf_cnt),
    .size            (req_size)
  );

  sdp_rdma_cube_walk u_cube_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .accept          (accept),
    .cfg             (cfg),
    .surf_cnt        (surf_cnt),
    .pos             (pos)
  );

  sdp_rdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .accept          (accept),
    .cfg             (cfg),
    .pos             (pos),
    .addr            (req_addr)
  );

  // perf counter
  sdp_rdma_stall_cnt u_stall_cnt (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_load            (op_load),
    .reg2dp_op_en       (reg2dp_op_en),
    .reg2dp_perf_dma_en (reg2dp_perf_dma_en),
    .dma_rd_req_vld     (dma_rd_req_vld),
    .dma_rd_req_rdy     (dma_rd_req_rdy),
    .dp2reg_rdma_stall  (dp2reg_rdma_stall)
  );

  // ==================
  // payloads
  // ==================

  // same size goes to dma and to the egress side
  assign dma_rd_req_pd.size = req_size;
  assign dma_rd_req_pd.addr = req_addr;
  assign ig2cq_pd.cube_end  = pos.cube_end;
  assign ig2cq_pd.size      = req_size;

endmodule

/* hw/sdp_rdma_ig_ctrl.sv */
`timescale 1ns/1ps

module sdp_rdma_ig_ctrl (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic op_load,
  input  logic cube_end,
  input  logic dma_rd_req_rdy,
  input  logic ig2cq_prdy,
  output logic dma_rd_req_vld,
  output logic ig2cq_pvld,
  output logic accept
);

  logic cmd_process;
  logic op_done;

  // ==================
  // op state
  // ==================

  // last request of the cube taken
  assign op_done = accept & cube_end;

  // set by op_load, cleared once cube end goes out
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_process <= 1'b0;
    end else if (op_load) begin
      cmd_process <= 1'b1;
    end else if (op_done) begin
      cmd_process <= 1'b0;
    end
  end

  // ==================
  // joint handshake
  // ==================

  // each valid waits on the other side's ready
  // so dma and cq always take the item together
  assign dma_rd_req_vld = cmd_process & ig2cq_prdy;
  assign ig2cq_pvld     = cmd_process & dma_rd_req_rdy;

  // one accept advances the whole walk
  assign accept = dma_rd_req_vld & dma_rd_req_rdy;

endmodule

/* hw/sdp_rdma_macros.svh */
`ifndef SDP_RDMA_MACROS_SVH
`define SDP_RDMA_MACROS_SVH

// ==================
// atom geometry
// ==================

// log2 of the 32 byte atom
`define SDP_RDMA_ATOM_SHIFT 5
// byte address on the dma bus
`define SDP_RDMA_ADDR_W 64
// same address counted in atoms
`define SDP_RDMA_ATOM_ADDR_W 59

// ==================
// field widths
// ==================

// request size, atoms minus one
`define SDP_RDMA_SIZE_W 15
// width, height and channel fields
`define SDP_RDMA_DIM_W 13
// line and surface stride in atoms
`define SDP_RDMA_STRIDE_W 27
// surface counter, one more bit than int8 needs
`define SDP_RDMA_SURF_CNT_W 9
// perf counter
`define SDP_RDMA_STALL_W 32

`endif

/* hw/sdp_rdma_pkg.sv */
`include "sdp_rdma_macros.svh"

package sdp_rdma_pkg;

  // processing precision as coded in the register
  typedef enum logic [1:0] {
    prec_int8  = 2'd0,
    prec_int16 = 2'd1,
    prec_fp16  = 2'd2
  } precision_e;

  // ==================
  // register config
  // ==================
  // high word plus low word form the atom base address
  typedef struct packed {
    logic [`SDP_RDMA_DIM_W-1:0]                         channel;
    logic [`SDP_RDMA_DIM_W-1:0]                         height;
    logic [`SDP_RDMA_DIM_W-1:0]                         width;
    precision_e                                         proc_precision;
    logic                                               data_mode;
    logic                                               data_size;
    logic [1:0]                                         data_use;
    logic [`SDP_RDMA_ATOM_ADDR_W-`SDP_RDMA_STRIDE_W-1:0] base_addr_high;
    logic [`SDP_RDMA_STRIDE_W-1:0]                      base_addr_low;
    logic [`SDP_RDMA_STRIDE_W-1:0]                      line_stride;
    logic [`SDP_RDMA_STRIDE_W-1:0]                      surface_stride;
  } rdma_cfg_t;

  // dma read request, size above addr
  typedef struct packed {
    logic [`SDP_RDMA_SIZE_W-1:0] size;
    logic [`SDP_RDMA_ADDR_W-1:0] addr;
  } dma_rd_req_t;

  // context queue entry for the egress side
  typedef struct packed {
    logic                        cube_end;
    logic [`SDP_RDMA_SIZE_W-1:0] size;
  } cq_entry_t;

  // where the current request sits in the cube
  typedef struct packed {
    logic line_end;
    logic surf_end;
    logic cube_end;
  } cube_pos_t;

endpackage

/* hw/sdp_rdma_req_size.sv */
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_req_size (
  input  sdp_rdma_pkg::rdma_cfg_t         cfg,
  input  logic                            reg2dp_op_en,
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,
  output logic [`SDP_RDMA_SURF_CNT_W-1:0] surf_cnt,
  output logic [`SDP_RDMA_SIZE_W-1:0]     size
);

  import sdp_rdma_pkg::*;

  logic                        prec_is_int8;
  logic                        prec_is_int16;
  logic                        size_1byte;
  logic                        use_both;
  logic                        mode_per_kernel;
  logic                        mode_1x1_pack;
  logic [1:0]                  elem_shift;
  logic [`SDP_RDMA_SIZE_W-1:0] size_of_straight;
  logic [`SDP_RDMA_SIZE_W-1:0] size_of_width;

  // n atoms times 1, 2 or 4, kept in minus one form
  function automatic logic [`SDP_RDMA_SIZE_W-1:0] scale_size(
    input logic [`SDP_RDMA_SIZE_W-1:0] n,
    input logic [1:0]                  sh
  );
    logic [`SDP_RDMA_SIZE_W-1:0] r;
    case (sh)
      2'd1:    r = {n[`SDP_RDMA_SIZE_W-2:0], 1'b1};
      2'd2:    r = {n[`SDP_RDMA_SIZE_W-3:0], 2'b11};
      default: r = n;
    endcase
    return r;
  endfunction

  // ==================
  // config decode
  // ==================

  assign prec_is_int8    = (cfg.proc_precision == prec_int8);
  assign prec_is_int16   = (cfg.proc_precision == prec_int16);
  assign size_1byte      = (cfg.data_size == 1'b0);
  assign use_both        = (cfg.data_use == 2'h2);
  assign mode_per_kernel = (cfg.data_mode == 1'b0);
  assign mode_1x1_pack   = (cfg.width == '0) && (cfg.height == '0);

  // surfaces minus one, 32 ch per surface for int8, 16 otherwise
  assign surf_cnt = prec_is_int8 ? {1'b0, cfg.channel[12:5]} : cfg.channel[12:4];

  // bytes per element as a shift
  // int8  1B single x1, 2B single or 1B both x2, 2B both x4
  // int16 single x1, both x2
  always_comb begin
    if (prec_is_int8) begin
      if (use_both) begin
        elem_shift = size_1byte ? 2'd1 : 2'd2;
      end else begin
        elem_shift = size_1byte ? 2'd0 : 2'd1;
      end
    end else begin
      elem_shift = use_both ? 2'd1 : 2'd0;
    end
  end

  // ==================
  // request size
  // ==================

  // whole cube in one go
  assign size_of_straight = scale_size(
    {{(`SDP_RDMA_SIZE_W-`SDP_RDMA_SURF_CNT_W){1'b0}}, surf_cnt}, elem_shift);
  // one line across the width
  assign size_of_width = scale_size(
    {{(`SDP_RDMA_SIZE_W-`SDP_RDMA_DIM_W){1'b0}}, cfg.width}, elem_shift);

  assign size = (mode_per_kernel || mode_1x1_pack) ? size_of_straight : size_of_width;

  // int16 has no 1 byte element
  a_int16_no_1byte: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(reg2dp_op_en && prec_is_int16 && size_1byte))
    else $error("1 byte data size used with int16 precision");

endmodule

/* hw/sdp_rdma_stall_cnt.sv */
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module sdp_rdma_stall_cnt (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic                         op_load,
  input  logic                         reg2dp_op_en,
  input  logic                         reg2dp_perf_dma_en,
  input  logic                         dma_rd_req_vld,
  input  logic                         dma_rd_req_rdy,
  output logic [`SDP_RDMA_STALL_W-1:0] dp2reg_rdma_stall
);

  logic stall_cen;
  logic stall_clr;
  logic stall_inc;

  // request offered but dma not taking it
  assign stall_inc = dma_rd_req_vld & ~dma_rd_req_rdy;
  assign stall_clr = op_load;
  // frozen unless op and perf both enabled
  assign stall_cen = reg2dp_op_en & reg2dp_perf_dma_en;

  // wraps at the top, clear wins over count
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_rdma_stall <= '0;
    end else if (stall_cen) begin
      if (stall_clr) begin
        dp2reg_rdma_stall <= '0;
      end else if (stall_inc) begin
        dp2reg_rdma_stall <= dp2reg_rdma_stall + 1'b1;
      end
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sdp_rdma_ig -f filelist.f

./obj_dir/Vtb_sdp_rdma_ig 2>&1 | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* testbench/sdp_rdma_input.txt */
// channel height width precision data_mode data_size data_use base_atoms line_stride
// surface_stride ready_mode perf_en expected_requests expected_last_byte_addr
3f 3 7 0 0 0 0 100 10 80 0 1 1 2000
5f 3 7 0 0 1 0 200 10 80 1 1 1 4000
20 1 4 0 0 0 2 3 4 8 2 1 1 60
7f 0 0 0 0 1 2 80001234 10 20 0 1 1 1000024680
2f 0 0 1 1 1 0 40 4 8 1 1 1 800
1f 0 0 1 1 1 2 50 4 8 2 0 1 a00
3f 2 4 0 1 0 0 1000 20 100 1 1 6 22800
1f 3 5 0 1 0 2 20 8 40 2 0 4 700
40 1 2 0 1 1 2 0 4 10 1 1 6 480
1f 2 3 1 1 1 0 300 10 40 2 1 6 6c00
f 4 6 1 1 1 2 400 6 200 1 1 5 8300
2a 0 1 2 1 1 0 7ff 2 3 0 1 3 100a0

/* testbench/tb_sdp_rdma_ig.sv */
`timescale 1ns/1ps
`include "sdp_rdma_macros.svh"

module tb_sdp_rdma_ig;

  import sdp_rdma_pkg::*;

  localparam int num_tests  = 12;
  localparam int num_fields = 14;

  logic                         nvdla_core_clk;
  logic                         nvdla_core_rstn;
  logic                         op_load;
  logic                         reg2dp_op_en;
  logic                         reg2dp_perf_dma_en;
  rdma_cfg_t                    cfg;
  dma_rd_req_t                  dma_rd_req_pd;
  logic                         dma_rd_req_vld;
  logic                         dma_rd_req_rdy;
  cq_entry_t                    ig2cq_pd;
  logic                         ig2cq_pvld;
  logic                         ig2cq_prdy;
  logic [`SDP_RDMA_STALL_W-1:0] dp2reg_rdma_stall;

  // one record of num_fields words per test
  logic [63:0]                  test_mem [0:num_tests*num_fields-1];
  logic [15:0]                  lfsr_state;
  int unsigned                  cycle_cnt;
  int unsigned                  cycle_limit;
  int unsigned                  rdy_mode;
  // reference walk state
  logic                         running;
  int unsigned                  ref_s;
  int unsigned                  ref_h;
  logic [63:0]                  ref_base;
  int unsigned                  seen_reqs;
  dma_rd_req_t                  last_req;
  logic [`SDP_RDMA_STALL_W-1:0] stall_exp;

  sdp_rdma_ig DUT (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_load            (op_load),
    .reg2dp_op_en       (reg2dp_op_en),
    .reg2dp_perf_dma_en (reg2dp_perf_dma_en),
    .cfg                (cfg),
    .dma_rd_req_pd      (dma_rd_req_pd),
    .dma_rd_req_vld     (dma_rd_req_vld),
    .dma_rd_req_rdy     (dma_rd_req_rdy),
    .ig2cq_pd           (ig2cq_pd),
    .ig2cq_pvld         (ig2cq_pvld),
    .ig2cq_prdy         (ig2cq_prdy),
    .dp2reg_rdma_stall  (dp2reg_rdma_stall)
  );

  initial nvdla_core_clk = 1'b0;
  always #5 nvdla_core_clk = ~nvdla_core_clk;

  // ==================
  // error reporting
  // ==================

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // run limit from the request totals
  always @(posedge nvdla_core_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      fail_run($sformatf("timeout: walk not finished after %0d cycles", cycle_cnt));
    end
  end

  task automatic check_req(input string name, input dma_rd_req_t got, input dma_rd_req_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got size 0x%0h addr 0x%0h exp size 0x%0h addr 0x%0h",
        name, got.size, got.addr, exp.size, exp.addr));
    end
  endtask

  task automatic check_cq(input string name, input cq_entry_t got, input cq_entry_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_stall(input string name, input logic [`SDP_RDMA_STALL_W-1:0] got,
                             input logic [`SDP_RDMA_STALL_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ==================
  // ready generation
  // ==================

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  // mode 0 always ready, 1 about half, 2 about three quarters
  task automatic draw_ready(output logic r);
    logic a;
    logic b;
    r = 1'b1;
    if (rdy_mode == 1) begin
      draw_bit(r);
    end else if (rdy_mode == 2) begin
      draw_bit(a);
      draw_bit(b);
      r = a | b;
    end
  endtask

  // ==================
  // reference walk
  // ==================

  // last surface index, 32 ch per int8 surface, 16 otherwise
  function automatic int unsigned ref_surf_last(input rdma_cfg_t c);
    if (c.proc_precision == prec_int8) begin
      return int'(c.channel) / 32;
    end
    return int'(c.channel) / 16;
  endfunction

  // per kernel or 1x1 cube, one request for all
  function automatic logic is_straight(input rdma_cfg_t c);
    return (c.data_mode == 1'b0) || (c.width == 0 && c.height == 0);
  endfunction

  // atoms times bytes per element, minus one
  function automatic logic [`SDP_RDMA_SIZE_W-1:0] ref_size(input rdma_cfg_t c);
    int unsigned atoms;
    int unsigned mult;
    logic [31:0] full;
    atoms = is_straight(c) ? ref_surf_last(c) + 1 : int'(c.width) + 1;
    if (c.proc_precision == prec_int8) begin
      mult = (c.data_use == 2'h2 ? 2 : 1) * (c.data_size ? 2 : 1);
    end else begin
      mult = (c.data_use == 2'h2) ? 2 : 1;
    end
    full = atoms * mult - 1;
    return full[`SDP_RDMA_SIZE_W-1:0];
  endfunction

  task automatic predict_req(output dma_rd_req_t r, output cq_entry_t q);
    logic [63:0] atom_addr;
    atom_addr = ref_base + 64'(ref_s) * cfg.surface_stride + 64'(ref_h) * cfg.line_stride;
    r.addr = atom_addr << `SDP_RDMA_ATOM_SHIFT;
    r.size = ref_size(cfg);
    q.size = r.size;
    q.cube_end = is_straight(cfg) || (ref_s == ref_surf_last(cfg) && ref_h == cfg.height);
  endtask

  // one clock, entered and left on the falling edge
  task automatic step_cycle(input logic load);
    logic                         exp_vld;
    logic                         exp_pvld;
    logic                         dma_take;
    dma_rd_req_t                  exp_req;
    cq_entry_t                    exp_cq;
    logic [`SDP_RDMA_STALL_W-1:0] stall_next;
    op_load = load;
    draw_ready(dma_rd_req_rdy);
    draw_ready(ig2cq_prdy);
    #1;
    check_stall("dp2reg_rdma_stall", dp2reg_rdma_stall, stall_exp);
    // each valid follows the other side's ready
    exp_vld  = running & ig2cq_prdy;
    exp_pvld = running & dma_rd_req_rdy;
    check_flag("dma_rd_req_vld", dma_rd_req_vld, exp_vld);
    check_flag("ig2cq_pvld", ig2cq_pvld, exp_pvld);
    predict_req(exp_req, exp_cq);
    if (running) begin
      check_req("dma_rd_req_pd", dma_rd_req_pd, exp_req);
      check_cq("ig2cq_pd", ig2cq_pd, exp_cq);
    end
    dma_take = dma_rd_req_vld & dma_rd_req_rdy;
    if (dma_take) begin
      last_req = dma_rd_req_pd;
    end
    // stalls counted only with op and perf enabled
    stall_next = stall_exp;
    if (reg2dp_op_en && reg2dp_perf_dma_en) begin
      if (load) begin
        stall_next = '0;
      end else if (exp_vld && !dma_rd_req_rdy) begin
        stall_next = stall_exp + 1'b1;
      end
    end
    @(posedge nvdla_core_clk);
    stall_exp = stall_next;
    if (load) begin
      running = 1'b1;
      ref_s = 0;
      ref_h = 0;
    end else if (dma_take) begin
      seen_reqs++;
      if (exp_cq.cube_end) begin
        running = 1'b0;
      end else if (ref_h == cfg.height) begin
        ref_h = 0;
        ref_s++;
      end else begin
        ref_h++;
      end
    end
    @(negedge nvdla_core_clk);
  endtask

  // ==================
  // test sequence
  // ==================

  task automatic run_test(input int t);
    dma_rd_req_t exp_last;
    int          b;
    b = t * num_fields;
    cfg.channel        = test_mem[b][12:0];
    cfg.height         = test_mem[b+1][12:0];
    cfg.width          = test_mem[b+2][12:0];
    cfg.proc_precision = precision_e'(test_mem[b+3][1:0]);
    cfg.data_mode      = test_mem[b+4][0];
    cfg.data_size      = test_mem[b+5][0];
    cfg.data_use       = test_mem[b+6][1:0];
    ref_base           = test_mem[b+7];
    cfg.base_addr_high = test_mem[b+7][58:27];
    cfg.base_addr_low  = test_mem[b+7][26:0];
    cfg.line_stride    = test_mem[b+8][26:0];
    cfg.surface_stride = test_mem[b+9][26:0];
    rdy_mode           = int'(test_mem[b+10]);
    reg2dp_perf_dma_en = test_mem[b+11][0];
    seen_reqs = 0;
    step_cycle(1'b1);
    while (running) begin
      step_cycle(1'b0);
    end
    // valids stay low once cube end is taken
    step_cycle(1'b0);
    step_cycle(1'b0);
    check_count("request count", seen_reqs, int'(test_mem[b+12]));
    exp_last.size = ref_size(cfg);
    exp_last.addr = test_mem[b+13];
    check_req("last dma_rd_req_pd", last_req, exp_last);
  endtask

  initial begin
    nvdla_core_rstn    = 1'b0;
    op_load            = 1'b0;
    reg2dp_op_en       = 1'b0;
    reg2dp_perf_dma_en = 1'b0;
    cfg                = '0;
    dma_rd_req_rdy     = 1'b0;
    ig2cq_prdy         = 1'b0;
    lfsr_state         = 16'd20;
    rdy_mode           = 1;
    running            = 1'b0;
    ref_s              = 0;
    ref_h              = 0;
    ref_base           = '0;
    seen_reqs          = 0;
    last_req           = '0;
    stall_exp          = '0;
    cycle_cnt          = 0;
    $readmemh("testbench/sdp_rdma_input.txt", test_mem);
    cycle_limit = 100;
    for (int t = 0; t < num_tests; t++) begin
      cycle_limit += int'(test_mem[t*num_fields+12]) * 8;
    end
    repeat (2) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    // idle after reset, valids low and stall at zero
    step_cycle(1'b0);
    step_cycle(1'b0);
    reg2dp_op_en = 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
